//--- build.f
rtl/requant_pkg.sv
rtl/accumulator_bank.sv
rtl/output_scaler.sv
rtl/output_scaler_set.sv
rtl/requant_top.sv
dv/tb_clock.sv
dv/tb_requant.sv

//--- dv/requant_cases.txt
# Commands: test name | scale n v.. | shift n v.. | clear p0..p7 | accum p0..p7
# both p0..p7 | idle n | expect y0..y7; decimal values, element 0 first.
test reset_zero
clear 100 -200 300 -400 500 -600 700 -800
expect 0 0 0 0 0 0 0 0
accum 1 1 1 1 1 1 1 1
idle 2
expect 0 0 0 0 0 0 0 0
test scale_wrap
scale 8 50 50 50 50 50 50 50 50
scale 8 1 2 3 4 5 6 7 8
clear 10 10 10 10 10 10 10 10
expect 10 20 30 40 50 60 70 80
test shift_wrap
shift 8 7 7 7 7 7 7 7 7
shift 8 0 1 2 3 4 5 6 7
clear 100 100 100 100 100 100 100 100
expect 100 100 75 50 31 19 11 6
test round_negative
scale 8 3 3 3 3 3 3 3 3
shift 8 0 1 2 2 3 3 4 0
clear -5 -5 -6 7 -10 10 -21 -40
expect -15 -7 -4 5 -4 4 -4 -120
test saturate
scale 8 1000 -1000 1000 -1000 32767 -32768 1 -1
shift 8 0 0 4 4 0 0 0 0
clear 1 1 2 3 -100 -100 127 128
expect 127 -128 125 -128 -128 127 127 -128
test accumulate
scale 8 1 1 1 1 1 1 1 1
shift 8 0 0 0 0 0 0 0 0
clear 1 2 3 4 5 6 7 8
accum 10 10 10 10 10 10 10 10
accum -20 -20 -20 -20 -20 -20 -20 -20
expect 1 2 3 4 5 6 7 8
expect 11 12 13 14 15 16 17 18
expect -9 -8 -7 -6 -5 -4 -3 -2
both 5 -5 50 -50 100 -100 0 127
expect 5 -5 50 -50 100 -100 0 127
test pipeline
scale 8 3 3 3 3 3 3 3 3
shift 8 1 1 1 1 1 1 1 1
clear 1 2 3 4 5 6 7 8
clear -1 -2 -3 -4 -5 -6 -7 -8
accum 10 10 10 10 10 10 10 10
expect 2 3 5 6 8 9 11 12
expect -1 -3 -4 -6 -7 -9 -10 -12
expect 14 12 11 9 8 6 5 3

//--- dv/tb_clock.sv
/*
 * Clock and reset source for the testbench.
 * 20 ns clock, active-low reset held for the first 5 rising edges.
 */
module tb_clock (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;  // ns.
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;  // Released on an edge, like the stimulus.
    end

endmodule

//--- dv/tb_requant.sv
/*
 * Testbench for requant_top. Reads dv/requant_cases.txt one command per line,
 * drives the DUT on rising edges and checks y_o against the expected vectors.
 */
module tb_requant
    import requant_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 50;  // Cycles any single wait may take.

    logic      clk;
    logic      nrst;
    logic      clear_i;
    logic      acc_en_i;
    pp_vec_t   pp_i;
    logic      cfg_we_i;
    cfg_sel_e  cfg_sel_i;
    cfg_word_u cfg_data_i;
    out_vec_t  y_o;

    int    fd;
    int    cyc;          // Rising edges seen by the stimulus process.
    int    settle_cyc;   // First cycle at which the last table write shows on y_o.
    int    pending [$];  // Output cycles of accumulator strobes not yet checked.
    int    vals [NUM_ELEMENTS];
    string test_name;
    int    test_errors;
    int    num_tests;
    int    num_checks;
    int    num_errors;
    bit    aborted;

    tb_clock u_tb_clock (
        .clk  (clk),
        .nrst (nrst)
    );

    requant_top requant_top_inst (
        .clk        (clk),
        .nrst       (nrst),
        .clear_i    (clear_i),
        .acc_en_i   (acc_en_i),
        .pp_i       (pp_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_data_i (cfg_data_i),
        .y_o        (y_o)
    );

    task automatic idle_cycle();
        @(posedge clk);
        cyc++;
        clear_i  <= 1'b0;
        acc_en_i <= 1'b0;
        cfg_we_i <= 1'b0;
    endtask

    task automatic read_values(input int n);
        int code;
        for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%d", vals[i]);
            if (code != 1 && !aborted) begin
                $display("ERROR: malformed value list in test %s", test_name);
                aborted = 1'b1;
            end
        end
    endtask

    // One accumulator strobe, output due two edges after the sampling edge.
    task automatic drive_acc(input logic clr, input logic acc);
        pp_vec_t v;
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            v[i] = pp_t'(vals[i]);
        end
        @(posedge clk);
        cyc++;
        clear_i  <= clr;
        acc_en_i <= acc;
        cfg_we_i <= 1'b0;
        pp_i     <= v;
        pending.push_back(cyc + 3);
    endtask

    // A burst of n table writes on consecutive cycles.
    task automatic write_cfg(input cfg_sel_e sel, input int n);
        cfg_word_u w;
        for (int i = 0; i < n; i++) begin
            w = '0;
            if (sel == CFG_SCALE) begin
                w.scale = scale_t'(vals[i]);
            end else begin
                w.shift_cfg.shift = shift_t'(vals[i]);
            end
            @(posedge clk);
            cyc++;
            clear_i    <= 1'b0;
            acc_en_i   <= 1'b0;
            cfg_we_i   <= 1'b1;
            cfg_sel_i  <= sel;
            cfg_data_i <= w;
        end
        settle_cyc = cyc + 3;
    endtask

    task automatic check_out(input int elem, input out_t exp, input out_t act);
        num_checks++;
        if (act !== exp) begin
            $display("MISMATCH %s element %0d: expected %0d, actual %0d",
                     test_name, elem, exp, act);
            test_errors++;
            num_errors++;
        end
    endtask

    task automatic expect_out();
        int target;
        int guard;
        target = settle_cyc;
        if (pending.size() > 0) begin
            guard = pending.pop_front();
            target = (guard > target) ? guard : target;
        end
        guard = 0;
        while (cyc < target && guard < WAIT_LIMIT) begin
            idle_cycle();
            guard++;
        end
        if (cyc < target) begin
            $display("ERROR: test %s timed out waiting for its output", test_name);
            aborted = 1'b1;
        end else begin
            @(negedge clk);  // Outputs settle after the rising edge.
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                check_out(i, out_t'(vals[i]), y_o[i]);
            end
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            if (test_errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    initial begin
        string cmd;
        string rest;
        int    code;
        int    n;
        int    guard;
        clear_i    = 1'b0;
        acc_en_i   = 1'b0;
        pp_i       = '0;
        cfg_we_i   = 1'b0;
        cfg_sel_i  = CFG_SCALE;
        cfg_data_i = '0;
        cyc         = 0;
        settle_cyc  = 0;
        test_name   = "";
        test_errors = 0;
        num_tests   = 0;
        num_checks  = 0;
        num_errors  = 0;
        aborted     = 1'b0;
        fd = $fopen("dv/requant_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the cases file dv/requant_cases.txt");
            aborted = 1'b1;
        end
        guard = 0;
        while (nrst !== 1'b1 && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (nrst !== 1'b1) begin
            $display("ERROR: reset was never released");
            aborted = 1'b1;
        end
        while (!aborted) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                break;
            end
            if (cmd.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (cmd == "test") begin
                finish_test();
                code = $fscanf(fd, "%s", test_name);
                num_tests++;
            end else if (cmd == "scale" || cmd == "shift") begin
                code = $fscanf(fd, "%d", n);
                if (code != 1 || n < 1 || n > NUM_ELEMENTS) begin
                    $display("ERROR: bad write count in test %s", test_name);
                    aborted = 1'b1;
                end else begin
                    read_values(n);
                    if (!aborted) begin
                        write_cfg((cmd == "scale") ? CFG_SCALE : CFG_SHIFT, n);
                    end
                end
            end else if (cmd == "clear" || cmd == "accum" || cmd == "both") begin
                read_values(NUM_ELEMENTS);
                if (!aborted) begin
                    drive_acc(cmd != "accum", cmd != "clear");
                end
            end else if (cmd == "idle") begin
                code = $fscanf(fd, "%d", n);
                for (int i = 0; i < n && i < WAIT_LIMIT; i++) begin
                    idle_cycle();
                end
            end else if (cmd == "expect") begin
                read_values(NUM_ELEMENTS);
                if (!aborted) begin
                    expect_out();
                end
            end else begin
                $display("ERROR: unknown command %s in the cases file", cmd);
                aborted = 1'b1;
            end
        end
        finish_test();
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests, num_checks, num_errors);
        if (num_errors == 0 && !aborted && num_checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/accumulator_bank.sv
/*
 * Bank of signed accumulators, one per output element.
 * clear_i loads the incoming partial products, acc_en_i adds them.
 */
module accumulator_bank
    import requant_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     clear_i,
    input  logic     acc_en_i,
    input  pp_vec_t  pp_i,
    output acc_vec_t acc_o
);

    acc_vec_t acc_q;
    acc_vec_t pp_ext;

    // Sign extension of every partial product to the accumulator width.
    always_comb begin
        for (int i = 0; i < NUM_ELEMENTS; i++) begin
            pp_ext[i] = acc_t'(pp_i[i]);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= pp_ext;  // Clear wins over accumulate.
        end else if (acc_en_i) begin
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                acc_q[i] <= acc_q[i] + pp_ext[i];  // Wraps on overflow.
            end
        end
    end

    assign acc_o = acc_q;

    // The strobes decide the next sum, so they must be clean once out of reset.
    strobes_known: assert property (
        @(posedge clk) disable iff (!nrst)
        !$isunknown({clear_i, acc_en_i})
    ) else $error("accumulator_bank: unknown strobe");

endmodule

//--- rtl/output_scaler.sv
/*
 * Requantizes one accumulated sum to a signed 8-bit activation.
 * Stage 1 multiplies by the scale, stage 2 rounds, shifts and saturates.
 * Latency is two cycles, a new sum is accepted every cycle.
 */
module output_scaler
    import requant_pkg::*;
(
    input  logic   clk,
    input  logic   nrst,
    input  acc_t   acc_i,
    input  scale_t scale_i,
    input  shift_t shift_i,
    output out_t   y_o
);

    // Signed output range, held at product width for the clamp.
    localparam logic signed [PROD_W-1:0] OUT_MAX = (PROD_W'(1) <<< (OUT_W - 1)) - 1;
    localparam logic signed [PROD_W-1:0] OUT_MIN = -(PROD_W'(1) <<< (OUT_W - 1));

    logic signed [PROD_W-1:0] prod_q;
    shift_t                   shift_q;
    logic signed [PROD_W-1:0] round_c;
    logic signed [PROD_W-1:0] rounded;
    logic signed [PROD_W-1:0] shifted;
    logic signed [PROD_W-1:0] resid;  // Product minus the output scaled back up.
    out_t                     sat_d;
    out_t                     y_q;

    // Stage 1.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prod_q  <= '0;
            shift_q <= '0;
        end else begin
            prod_q  <= acc_i * scale_i;  // Full width, cannot overflow.
            shift_q <= shift_i;          // Travels with its product.
        end
    end

    // Stage 2 arithmetic.
    always_comb begin
        if (shift_q == '0) begin
            round_c = '0;
        end else begin
            round_c = PROD_W'(1) << (shift_q - 1'b1);  // Half a unit of the shift.
        end
        rounded = prod_q + round_c;
        shifted = rounded >>> shift_q;
        if (shifted > OUT_MAX) begin
            sat_d = OUT_MAX[OUT_W-1:0];
        end else if (shifted < OUT_MIN) begin
            sat_d = OUT_MIN[OUT_W-1:0];
        end else begin
            sat_d = shifted[OUT_W-1:0];
        end
    end

    assign resid = prod_q - (PROD_W'(sat_d) <<< shift_q);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_q <= '0;
        end else begin
            y_q <= sat_d;
        end
    end

    assign y_o = y_q;

    // Unclamped results stay within half a unit of the exact product.
    round_err: assert property (
        @(posedge clk) disable iff (!nrst)
        ((shifted <= OUT_MAX) && (shifted >= OUT_MIN)) |->
            (resid >= -round_c) && ((shift_q == '0) ? (resid == '0) : (resid < round_c))
    ) else $error("output_scaler: result not rounded to nearest");

endmodule

//--- rtl/output_scaler_set.sv
/*
 * Scale and shift tables plus one output scaler per element.
 * Each table is filled in element order through its own wrapping
 * write pointer, one entry per write strobe.
 */
module output_scaler_set
    import requant_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  acc_vec_t wx_i,
    input  logic     scale_we_i,
    input  scale_t   scale_data_i,
    input  logic     shift_we_i,
    input  shift_t   shift_data_i,
    output out_vec_t y_o
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NUM_ELEMENTS - 1);

    scale_t              scale_tab [NUM_ELEMENTS];
    shift_t              shift_tab [NUM_ELEMENTS];
    logic   [ADDR_W-1:0] scale_ptr;
    logic   [ADDR_W-1:0] shift_ptr;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_ELEMENTS; i++) begin
                scale_tab[i] <= '0;
                shift_tab[i] <= '0;
            end
            scale_ptr <= '0;
            shift_ptr <= '0;
        end else begin
            if (scale_we_i) begin
                scale_tab[scale_ptr] <= scale_data_i;
                scale_ptr <= (scale_ptr == LAST_ADDR) ? '0 : scale_ptr + 1'b1;
            end
            // Shift pointer runs independently of the scale pointer.
            if (shift_we_i) begin
                shift_tab[shift_ptr] <= shift_data_i;
                shift_ptr <= (shift_ptr == LAST_ADDR) ? '0 : shift_ptr + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NUM_ELEMENTS; i++) begin : g_scaler
        output_scaler u_output_scaler (
            .clk     (clk),
            .nrst    (nrst),
            .acc_i   (wx_i[i]),
            .scale_i (scale_tab[i]),
            .shift_i (shift_tab[i]),
            .y_o     (y_o[i])
        );
    end

    // Write strobes move the table pointers, so they must be clean once out of reset.
    we_known: assert property (
        @(posedge clk) disable iff (!nrst)
        !$isunknown({scale_we_i, shift_we_i})
    ) else $error("output_scaler_set: unknown write strobe");

endmodule

//--- rtl/requant_pkg.sv
/*
 * Shared widths and types for the requantization back end.
 * Every RTL module imports this package in its header.
 */
package requant_pkg;

    // Sizes.
    localparam int NUM_ELEMENTS = 8;
    localparam int ADDR_W       = 3;
    localparam int PP_W         = 16;
    localparam int ACC_W        = 20;
    localparam int SCALE_W      = 16;
    localparam int SHIFT_W      = 4;
    localparam int OUT_W        = 8;
    localparam int PROD_W       = ACC_W + SCALE_W;

    // One element of each kind.
    typedef logic signed [PP_W-1:0]    pp_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef logic signed [SCALE_W-1:0] scale_t;
    typedef logic        [SHIFT_W-1:0] shift_t;  // Unsigned shift amount.
    typedef logic signed [OUT_W-1:0]   out_t;

    // Whole vectors, element 0 in the low bits.
    typedef pp_t  [NUM_ELEMENTS-1:0] pp_vec_t;
    typedef acc_t [NUM_ELEMENTS-1:0] acc_vec_t;
    typedef out_t [NUM_ELEMENTS-1:0] out_vec_t;

    // Shift view of the configuration word.
    typedef struct packed {
        logic [SCALE_W-SHIFT_W-1:0] reserved;
        shift_t                     shift;
    } cfg_shift_s;

    // One configuration word, read as a scale or as a shift.
    typedef union packed {
        scale_t     scale;
        cfg_shift_s shift_cfg;
    } cfg_word_u;

    typedef enum logic {
        CFG_SCALE = 1'b0,
        CFG_SHIFT = 1'b1
    } cfg_sel_e;

endpackage

//--- rtl/requant_top.sv
/*
 * Requantization back end: accumulator bank feeding the scaler set.
 * The configuration bus is split here into scale and shift write ports.
 * y_o follows an accumulator strobe by two cycles.
 */
module requant_top
    import requant_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      clear_i,
    input  logic      acc_en_i,
    input  pp_vec_t   pp_i,
    input  logic      cfg_we_i,
    input  cfg_sel_e  cfg_sel_i,
    input  cfg_word_u cfg_data_i,
    output out_vec_t  y_o
);

    acc_vec_t acc_vec;
    logic     scale_we;
    logic     shift_we;

    // Select decides which table takes the word.
    assign scale_we = cfg_we_i && (cfg_sel_i == CFG_SCALE);
    assign shift_we = cfg_we_i && (cfg_sel_i == CFG_SHIFT);

    accumulator_bank u_accumulator_bank (
        .clk      (clk),
        .nrst     (nrst),
        .clear_i  (clear_i),
        .acc_en_i (acc_en_i),
        .pp_i     (pp_i),
        .acc_o    (acc_vec)
    );

    output_scaler_set u_output_scaler_set (
        .clk          (clk),
        .nrst         (nrst),
        .wx_i         (acc_vec),
        .scale_we_i   (scale_we),
        .scale_data_i (cfg_data_i.scale),
        .shift_we_i   (shift_we),
        .shift_data_i (cfg_data_i.shift_cfg.shift),  // Reserved bits ignored.
        .y_o          (y_o)
    );

endmodule
